//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f filelist.f \
		--top-module ucstats_tb -Mdir obj_dir
	out=$$(./obj_dir/Vucstats_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- filelist.f
+incdir+tb
hdl/ucstats_pkg.sv
hdl/uc_xfer_if.sv
hdl/uc_pin_sync.sv
hdl/uc_xfer_fsm.sv
hdl/uc_addr_ctr.sv
hdl/uc_xfer_regs.sv
hdl/stat_bank_ram.sv
hdl/bank_swap_ctl.sv
hdl/ucstats_top.sv
tb/ucstats_tb.sv

//--- hdl/bank_swap_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module bank_swap_ctl (
   input  logic      clk,
   input  logic      uc_rst_n,
   uc_xfer_if.bank   x,
   input  logic      le_req,
   input  logic      le_done,
   output logic      gnt,
   output logic      wr_bank
);
   ucstats_pkg::bank_state_e state;
   logic                     le_busy_q;
   logic                     le_busy;

   // outstanding link engine read, from req up to done
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         le_busy_q <= 1'b0;
         gnt       <= 1'b0;
      end else begin
         if (le_req) begin
            le_busy_q <= 1'b1;
         end else if (le_done) begin
            le_busy_q <= 1'b0;
         end
         // grant trails req by one cycle
         gnt <= le_req;
      end
   end

   assign le_busy = le_busy_q | le_req;

   // --------------------------------------------------
   // swap sequencing
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state <= ucstats_pkg::BANK_IDLE;
      end else begin
         case (state)
            ucstats_pkg::BANK_IDLE:
               if (x.wr_ram) state <= ucstats_pkg::BANK_WRITING;
            ucstats_pkg::BANK_WRITING:
               if (x.interval_hit) state <= ucstats_pkg::BANK_INTERVAL_DONE;
            // new write cancels, engine read holds the swap off
            ucstats_pkg::BANK_INTERVAL_DONE:
               if (x.wr_ram) begin
                  state <= ucstats_pkg::BANK_WRITING;
               end else if (!le_busy) begin
                  state <= ucstats_pkg::BANK_UPDATE;
               end
            default:
               state <= ucstats_pkg::BANK_IDLE;
         endcase
      end
   end

   // bank the microcontroller writes
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         wr_bank <= 1'b0;
      end else if (state == ucstats_pkg::BANK_UPDATE) begin
         wr_bank <= ~wr_bank;
      end
   end

endmodule

`default_nettype wire

//--- hdl/stat_bank_ram.sv
`timescale 1ns/100ps
`default_nettype none

module stat_bank_ram (
   input  logic                   clk,
   input  logic                   uc_rst_n,
   uc_xfer_if.ram                  x,
   input  ucstats_pkg::stat_word_t wdata,
   input  logic                   wr_bank,
   input  ucstats_pkg::stat_addr_t le_addr,
   output ucstats_pkg::stat_word_t rd_word,
   output ucstats_pkg::stat_word_t ucstats_data
);

   // --------------------------------------------------
   // one simple dual port array per bank
   // the microcontroller owns bank wr_bank, the link engine the other
   for (genvar b = 0; b < ucstats_pkg::NUM_BANKS; b++) begin : g_bank
      ucstats_pkg::stat_word_t mem [ucstats_pkg::BANK_DEPTH];
      ucstats_pkg::stat_word_t q;
      ucstats_pkg::stat_addr_t raddr;
      logic                    uc_owned;

      assign uc_owned = (wr_bank == 1'(b));
      assign raddr    = uc_owned ? x.addr.f.idx : le_addr;

      always_ff @(posedge clk) begin
         if (x.wr_ram && uc_owned) begin
            mem[x.addr.f.idx] <= wdata;
         end
         q <= mem[raddr];
      end
   end

   // microcontroller word from its own bank
   assign rd_word = wr_bank ? g_bank[1].q : g_bank[0].q;

   // link engine output register, data lands 2 cycles after le_addr
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         ucstats_data <= '0;
      end else begin
         ucstats_data <= wr_bank ? g_bank[0].q : g_bank[1].q;
      end
   end

endmodule

`default_nettype wire

//--- hdl/uc_addr_ctr.sv
`timescale 1ns/100ps
`default_nettype none

module uc_addr_ctr (
   input  logic                 clk,
   input  logic                 uc_rst_n,
   input  ucstats_pkg::uc_byte_t data_s,
   uc_xfer_if.ctr               x
);
   logic fpga_space;

   // address bytes land by beat, index steps after each stored word
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         x.addr <= '0;
      end else if (x.addr_ld) begin
         x.addr.bytes[x.beat[0]] <= data_s;
      end else if (x.wr_ram) begin
         x.addr.f.idx <= x.addr.f.idx + 1'b1;
      end
   end

   assign fpga_space = (x.addr.f.space == ucstats_pkg::SPACE_FPGA);

   // reserved bits, unknown space, or an unmapped fpga word
   assign x.invalid = (x.addr.f.rsvd != 3'd0) ||
                      (x.addr.f.space > ucstats_pkg::SPACE_FPGA) ||
                      (fpga_space && (x.addr.f.idx != ucstats_pkg::IDX_INTERVAL) &&
                                     (x.addr.f.idx != ucstats_pkg::IDX_CODE));

   // end of interval marker
   assign x.interval_hit = x.addr.f.wr && fpga_space &&
                           (x.addr.f.idx == ucstats_pkg::IDX_INTERVAL);

endmodule

`default_nettype wire

//--- hdl/uc_pin_sync.sv
`timescale 1ns/100ps
`default_nettype none

module uc_pin_sync (
   input  logic                 clk,
   input  logic                 uc_rst_n,
   input  logic                 cs,
   input  logic                 valid,
   input  logic                 master,
   input  ucstats_pkg::uc_byte_t data_in,
   output logic                 cs_s,
   output logic                 master_s,
   output logic                 valid_rise,
   output logic                 valid_fall,
   output ucstats_pkg::uc_byte_t data_s
);
   // packed as {cs, master, valid, data}
   logic [ucstats_pkg::UC_BYTE_W+2:0] meta;
   logic [ucstats_pkg::UC_BYTE_W+2:0] sync;
   logic                              valid_s;
   logic                              valid_d;

   // two flops per pin, then one more on the strobe for edges
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         meta    <= '0;
         sync    <= '0;
         valid_d <= 1'b0;
      end else begin
         meta    <= {cs, master, valid, data_in};
         sync    <= meta;
         valid_d <= valid_s;
      end
   end

   assign cs_s     = sync[ucstats_pkg::UC_BYTE_W+2];
   assign master_s = sync[ucstats_pkg::UC_BYTE_W+1];
   assign valid_s  = sync[ucstats_pkg::UC_BYTE_W];
   assign data_s   = sync[ucstats_pkg::UC_BYTE_W-1:0];

   // single cycle pulses
   assign valid_rise = valid_s & ~valid_d;
   assign valid_fall = ~valid_s & valid_d;

endmodule

`default_nettype wire

//--- hdl/uc_xfer_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module uc_xfer_fsm (
   input  logic     clk,
   input  logic     uc_rst_n,
   input  logic     cs_s,
   input  logic     master_s,
   input  logic     valid_rise,
   input  logic     valid_fall,
   uc_xfer_if.fsm   x,
   output logic     data_out_val
);
   ucstats_pkg::uc_state_e state;
   logic                   stat_space;
   logic [1:0]             beat;

   assign stat_space = (x.addr.f.space == ucstats_pkg::SPACE_STAT);

   // --------------------------------------------------
   // sequencing, cs low returns to idle from any state
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         state <= ucstats_pkg::UC_IDLE;
      end else if (!cs_s) begin
         state <= ucstats_pkg::UC_IDLE;
      end else begin
         case (state)
            ucstats_pkg::UC_IDLE:
               state <= ucstats_pkg::UC_ADDR0;
            // address bytes, low first
            ucstats_pkg::UC_ADDR0:
               if (valid_rise) state <= ucstats_pkg::UC_ADDR1;
            ucstats_pkg::UC_ADDR1:
               if (valid_rise) state <= ucstats_pkg::UC_DEC;
            ucstats_pkg::UC_DEC: begin
               if (x.addr.f.wr) begin
                  // bad write or write to the code word, wait for cs
                  if (x.invalid || !(stat_space || x.interval_hit)) begin
                     state <= ucstats_pkg::UC_DONE;
                  end else begin
                     state <= ucstats_pkg::UC_DATA0;
                  end
               end else if (x.invalid) begin
                  // no ram read, word is already BAD_WORD
                  state <= ucstats_pkg::UC_RD_FALL;
               end else begin
                  state <= ucstats_pkg::UC_RD_RAM;
               end
            end
            // write data beats
            ucstats_pkg::UC_DATA0:
               if (valid_rise) state <= ucstats_pkg::UC_DATA1;
            ucstats_pkg::UC_DATA1:
               if (valid_rise) state <= ucstats_pkg::UC_DATA2;
            ucstats_pkg::UC_DATA2:
               if (valid_rise) state <= ucstats_pkg::UC_DATA3;
            ucstats_pkg::UC_DATA3:
               // marker word is not stored, next group follows
               if (valid_rise) begin
                  state <= stat_space ? ucstats_pkg::UC_WR_RAM : ucstats_pkg::UC_DATA0;
               end
            ucstats_pkg::UC_WR_RAM:
               state <= ucstats_pkg::UC_DATA0;
            // read path
            ucstats_pkg::UC_RD_RAM:
               state <= ucstats_pkg::UC_RD_FALL;
            ucstats_pkg::UC_RD_FALL:
               if (valid_fall) state <= ucstats_pkg::UC_RD_MASTER;
            ucstats_pkg::UC_RD_MASTER:
               if (!master_s) state <= ucstats_pkg::UC_DRIVE0;
            ucstats_pkg::UC_DRIVE0:
               if (valid_fall) state <= ucstats_pkg::UC_DRIVE1;
            ucstats_pkg::UC_DRIVE1:
               if (valid_fall) state <= ucstats_pkg::UC_DRIVE2;
            ucstats_pkg::UC_DRIVE2:
               if (valid_fall) state <= ucstats_pkg::UC_DRIVE3;
            ucstats_pkg::UC_DRIVE3:
               if (valid_fall) state <= ucstats_pkg::UC_DONE;
            // hold until cs drops
            ucstats_pkg::UC_DONE:
               state <= ucstats_pkg::UC_DONE;
            default:
               state <= ucstats_pkg::UC_IDLE;
         endcase
      end
   end

   // --------------------------------------------------
   // byte position within the current word
   always_comb begin
      case (state)
         ucstats_pkg::UC_ADDR1, ucstats_pkg::UC_DATA1, ucstats_pkg::UC_DRIVE1: beat = 2'd1;
         ucstats_pkg::UC_DATA2, ucstats_pkg::UC_DRIVE2:                        beat = 2'd2;
         ucstats_pkg::UC_DATA3, ucstats_pkg::UC_DRIVE3:                        beat = 2'd3;
         default:                                                              beat = 2'd0;
      endcase
   end

   assign x.beat    = beat;
   assign x.addr_ld = valid_rise &&
                      (state inside {ucstats_pkg::UC_ADDR0, ucstats_pkg::UC_ADDR1});
   assign x.data_ld = valid_rise &&
                      (state inside {ucstats_pkg::UC_DATA0, ucstats_pkg::UC_DATA1,
                                     ucstats_pkg::UC_DATA2, ucstats_pkg::UC_DATA3});
   assign x.wr_ram  = (state == ucstats_pkg::UC_WR_RAM);
   assign x.rd_ram  = (state == ucstats_pkg::UC_RD_RAM);
   assign x.chk     = (state == ucstats_pkg::UC_DEC);
   assign x.drive   = state inside {ucstats_pkg::UC_DRIVE0, ucstats_pkg::UC_DRIVE1,
                                    ucstats_pkg::UC_DRIVE2, ucstats_pkg::UC_DRIVE3};

   // pad enable follows the drive beats
   assign data_out_val = x.drive;

endmodule

`default_nettype wire

//--- hdl/uc_xfer_if.sv
`timescale 1ns/100ps
`default_nettype none

// strobes and address decode shared on the microcontroller side
interface uc_xfer_if;
   // driven by the transfer FSM
   logic [1:0] beat;
   logic       addr_ld;
   logic       data_ld;
   logic       wr_ram;
   logic       rd_ram;
   logic       drive;
   logic       chk;
   // driven by the address counter
   ucstats_pkg::uc_addr_u addr;
   logic                  invalid;
   logic                  interval_hit;

   modport fsm  (output beat, addr_ld, data_ld, wr_ram, rd_ram, drive, chk,
                 input  addr, invalid, interval_hit);
   modport ctr  (input  beat, addr_ld, wr_ram,
                 output addr, invalid, interval_hit);
   modport regs (input  beat, data_ld, rd_ram, drive, chk, addr, invalid);
   modport ram  (input  wr_ram, addr);
   modport bank (input  wr_ram, interval_hit);
endinterface

`default_nettype wire

//--- hdl/uc_xfer_regs.sv
`timescale 1ns/100ps
`default_nettype none

module uc_xfer_regs (
   input  logic                   clk,
   input  logic                   uc_rst_n,
   input  ucstats_pkg::uc_byte_t   data_s,
   input  ucstats_pkg::stat_word_t rd_word,
   uc_xfer_if.regs                 x,
   output ucstats_pkg::stat_word_t wdata,
   output ucstats_pkg::uc_byte_t   data_out
);
   ucstats_pkg::stat_word_t rword;
   logic                    code_hit;
   logic                    stat_hit;

   // write word, one byte per data strobe
   always_ff @(posedge clk) begin
      if (x.data_ld) begin
         wdata[x.beat*ucstats_pkg::UC_BYTE_W +: ucstats_pkg::UC_BYTE_W] <= data_s;
      end
   end

   assign code_hit = (x.addr.f.space == ucstats_pkg::SPACE_FPGA) &&
                     (x.addr.f.idx == ucstats_pkg::IDX_CODE);
   assign stat_hit = (x.addr.f.space == ucstats_pkg::SPACE_STAT);

   // --------------------------------------------------
   // read word
   // fixed words at decode, bank word one state later
   always_ff @(posedge clk or negedge uc_rst_n) begin
      if (!uc_rst_n) begin
         rword <= '0;
      end else if (x.chk) begin
         if (x.invalid) begin
            rword <= ucstats_pkg::BAD_WORD;
         end else if (code_hit) begin
            rword <= ucstats_pkg::CODE_WORD;
         end else begin
            // interval marker reads back as zero
            rword <= '0;
         end
      end else if (x.rd_ram && stat_hit) begin
         rword <= rd_word;
      end
   end

   // byte 0 first, quiet between drive beats
   assign data_out = x.drive ?
                     rword[x.beat*ucstats_pkg::UC_BYTE_W +: ucstats_pkg::UC_BYTE_W] : '0;

endmodule

`default_nettype wire

//--- hdl/ucstats_pkg.sv
`default_nettype none

package ucstats_pkg;

   // widths and bank geometry
   localparam int UC_BYTE_W   = 8;
   localparam int STAT_WORD_W = 32;
   localparam int STAT_ADDR_W = 10;
   localparam int BANK_DEPTH  = 1 << STAT_ADDR_W;
   localparam int NUM_BANKS   = 2;

   typedef logic [UC_BYTE_W-1:0]   uc_byte_t;
   typedef logic [STAT_WORD_W-1:0] stat_word_t;
   // link engine view: sfp in [9:5], word in [4:0]
   typedef logic [STAT_ADDR_W-1:0] stat_addr_t;

   // --------------------------------------------------
   // transfer address, bytes as loaded or fields as decoded
   typedef union packed {
      uc_byte_t [1:0] bytes;
      struct packed {
         logic       wr;
         logic [2:0] rsvd;
         logic [1:0] space;
         stat_addr_t idx;
      } f;
   } uc_addr_u;

   // address map
   localparam logic [1:0] SPACE_STAT   = 2'd0;
   localparam logic [1:0] SPACE_FPGA   = 2'd1;
   localparam stat_addr_t IDX_INTERVAL = 10'd1;
   localparam stat_addr_t IDX_CODE     = 10'd2;

   localparam stat_word_t CODE_WORD = 32'hC001C0DE;
   localparam stat_word_t BAD_WORD  = 32'hDEADBEEF;

   // --------------------------------------------------
   typedef enum logic [4:0] {
      UC_IDLE, UC_ADDR0, UC_ADDR1, UC_DEC,
      UC_DATA0, UC_DATA1, UC_DATA2, UC_DATA3,
      UC_WR_RAM, UC_RD_RAM, UC_RD_FALL, UC_RD_MASTER,
      UC_DRIVE0, UC_DRIVE1, UC_DRIVE2, UC_DRIVE3,
      UC_DONE
   } uc_state_e;

   typedef enum logic [1:0] {
      BANK_IDLE, BANK_WRITING, BANK_INTERVAL_DONE, BANK_UPDATE
   } bank_state_e;

endpackage

`default_nettype wire

//--- hdl/ucstats_top.sv
`timescale 1ns/100ps
`default_nettype none

module ucstats_top (
   input  logic                   clk,
   input  logic                   uc_rst_n,
   // microcontroller pins
   input  logic                   cs,
   input  logic                   valid,
   input  logic                   master,
   input  ucstats_pkg::uc_byte_t   data_in,
   output ucstats_pkg::uc_byte_t   data_out,
   output logic                   data_out_val,
   // link engine
   input  logic                   le_req,
   input  ucstats_pkg::stat_addr_t le_addr,
   input  logic                   le_done,
   output ucstats_pkg::stat_word_t ucstats_data,
   output logic                   gnt
);
   logic                    cs_s;
   logic                    master_s;
   logic                    valid_rise;
   logic                    valid_fall;
   logic                    wr_bank;
   ucstats_pkg::uc_byte_t   data_s;
   ucstats_pkg::stat_word_t wdata;
   ucstats_pkg::stat_word_t rd_word;

   uc_xfer_if x ();

   // --------------------------------------------------
   uc_pin_sync i_uc_pin_sync (
      .clk        (clk),
      .uc_rst_n   (uc_rst_n),
      .cs         (cs),
      .valid      (valid),
      .master     (master),
      .data_in    (data_in),
      .cs_s       (cs_s),
      .master_s   (master_s),
      .valid_rise (valid_rise),
      .valid_fall (valid_fall),
      .data_s     (data_s)
   );

   uc_xfer_fsm i_uc_xfer_fsm (
      .clk          (clk),
      .uc_rst_n     (uc_rst_n),
      .cs_s         (cs_s),
      .master_s     (master_s),
      .valid_rise   (valid_rise),
      .valid_fall   (valid_fall),
      .x            (x.fsm),
      .data_out_val (data_out_val)
   );

   uc_addr_ctr i_uc_addr_ctr (
      .clk      (clk),
      .uc_rst_n (uc_rst_n),
      .data_s   (data_s),
      .x        (x.ctr)
   );

   uc_xfer_regs i_uc_xfer_regs (
      .clk      (clk),
      .uc_rst_n (uc_rst_n),
      .data_s   (data_s),
      .rd_word  (rd_word),
      .x        (x.regs),
      .wdata    (wdata),
      .data_out (data_out)
   );

   // --------------------------------------------------
   stat_bank_ram i_stat_bank_ram (
      .clk          (clk),
      .uc_rst_n     (uc_rst_n),
      .x            (x.ram),
      .wdata        (wdata),
      .wr_bank      (wr_bank),
      .le_addr      (le_addr),
      .rd_word      (rd_word),
      .ucstats_data (ucstats_data)
   );

   bank_swap_ctl i_bank_swap_ctl (
      .clk      (clk),
      .uc_rst_n (uc_rst_n),
      .x        (x.bank),
      .le_req   (le_req),
      .le_done  (le_done),
      .gnt      (gnt),
      .wr_bank  (wr_bank)
   );

endmodule

`default_nettype wire

//--- tb/ucstats_tests.svh
`ifndef UCSTATS_TESTS_SVH
`define UCSTATS_TESTS_SVH

localparam ucstats_pkg::stat_addr_t RB_BASE = 10'h040;
// sfp 9, word 0
localparam ucstats_pkg::stat_addr_t LE_BASE = 10'h120;
localparam ucstats_pkg::stat_addr_t AB_BASE = 10'h200;

ucstats_pkg::stat_word_t words_a [BURST_LEN];
ucstats_pkg::stat_word_t words_b [BURST_LEN];

// --------------------------------------------------
// address words: wr, reserved, space, index
function automatic logic [15:0] stat_space_addr(input logic wr,
                                                input ucstats_pkg::stat_addr_t idx);
   return {wr, 3'b000, 2'b00, idx};
endfunction

function automatic logic [15:0] fpga_space_addr(input logic wr,
                                                input ucstats_pkg::stat_addr_t idx);
   return {wr, 3'b000, 2'b01, idx};
endfunction

task automatic fill_random(output ucstats_pkg::stat_word_t w [BURST_LEN]);
   for (int i = 0; i < BURST_LEN; i++) begin
      w[i] = $urandom();
   end
endtask

// end of interval, one data word of zero
task automatic mark_interval;
   ucstats_pkg::stat_word_t zero [BURST_LEN];
   for (int i = 0; i < BURST_LEN; i++) begin
      zero[i] = '0;
   end
   uc_write_burst(fpga_space_addr(1'b1, 10'd1), zero, 1);
endtask

// --------------------------------------------------
task automatic test_burst_readback;
   fill_random(words_a);
   uc_write_burst(stat_space_addr(1'b1, RB_BASE), words_a, BURST_LEN);
   for (int i = 0; i < BURST_LEN; i++) begin
      uc_read("burst_readback", stat_space_addr(1'b0, RB_BASE + 10'(i)), words_a[i], 4);
   end
endtask

task automatic test_fixed_and_invalid;
   uc_read("code_word", fpga_space_addr(1'b0, 10'd2), 32'hC001C0DE, 4);
   uc_read("reserved_bit", stat_space_addr(1'b0, RB_BASE) | 16'h1000, 32'hDEADBEEF, 4);
   uc_read("bad_space", 16'h0800, 32'hDEADBEEF, 4);
   uc_read("bad_fpga_index", fpga_space_addr(1'b0, 10'd3), 32'hDEADBEEF, 4);
   // write with a reserved bit over a stored word, which must survive
   fill_random(words_b);
   uc_write_burst(stat_space_addr(1'b1, RB_BASE + 10'd1) | 16'h1000, words_b, 1);
   uc_read("invalid_write", stat_space_addr(1'b0, RB_BASE + 10'd1), words_a[1], 4);
endtask

task automatic test_swap_and_le_read;
   fill_random(words_a);
   uc_write_burst(stat_space_addr(1'b1, LE_BASE), words_a, BURST_LEN);
   mark_interval();
   wait_cycles(SWAP_WAIT);
   le_read("le_after_swap", LE_BASE, words_a, BURST_LEN);
   le_done_pulse();
endtask

// engine read left open, so the next marker has to wait for done
task automatic test_deferred_swap;
   le_read("le_old_open", LE_BASE, words_a, BURST_LEN);
   fill_random(words_b);
   uc_write_burst(stat_space_addr(1'b1, LE_BASE), words_b, BURST_LEN);
   mark_interval();
   wait_cycles(SWAP_WAIT);
   le_read("le_old_pending", LE_BASE, words_a, BURST_LEN);
   le_done_pulse();
   wait_cycles(SWAP_WAIT);
   le_read("le_new_after_done", LE_BASE, words_b, BURST_LEN);
   le_done_pulse();
endtask

task automatic test_cs_abort;
   fill_random(words_b);
   uc_write_burst(stat_space_addr(1'b1, AB_BASE), words_b, 2);
   // write cut after two data bytes stores nothing
   uc_start(stat_space_addr(1'b1, AB_BASE));
   send_byte(~words_b[0][7:0]);
   send_byte(~words_b[0][15:8]);
   uc_end();
   uc_read("after_write_abort", stat_space_addr(1'b0, AB_BASE), words_b[0], 4);
   // read cut while byte 2 is on the pins
   uc_read("read_abort", stat_space_addr(1'b0, AB_BASE + 10'd1), words_b[1], 2);
   uc_read("after_read_abort", stat_space_addr(1'b0, AB_BASE + 10'd1), words_b[1], 4);
endtask

// --------------------------------------------------
task automatic run_all_tests;
   test_burst_readback();
   test_fixed_and_invalid();
   test_swap_and_le_read();
   test_deferred_swap();
   test_cs_abort();
endtask

`endif

//--- tb/ucstats_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ucstats_tb;

   localparam int CLK_PERIOD  = 100;
   // strobe half period in clocks, covers the 2 flop sync and fsm steps
   localparam int HOLD_CYCLES = 4;
   localparam int BURST_LEN   = 8;
   localparam int NUM_TESTS   = 5;
   localparam int TEST_CYCLES = 3000;
   localparam int WAIT_LIMIT  = 50;
   localparam int SWAP_WAIT   = 4;

   logic                    clk;
   logic                    uc_rst_n;
   logic                    cs;
   logic                    valid;
   logic                    master;
   ucstats_pkg::uc_byte_t   data_in;
   ucstats_pkg::uc_byte_t   data_out;
   logic                    data_out_val;
   logic                    le_req;
   ucstats_pkg::stat_addr_t le_addr;
   logic                    le_done;
   ucstats_pkg::stat_word_t ucstats_data;
   logic                    gnt;
   int                      release_grace;

   ucstats_top i_ucstats_top (
      .clk          (clk),
      .uc_rst_n     (uc_rst_n),
      .cs           (cs),
      .valid        (valid),
      .master       (master),
      .data_in      (data_in),
      .data_out     (data_out),
      .data_out_val (data_out_val),
      .le_req       (le_req),
      .le_addr      (le_addr),
      .le_done      (le_done),
      .ucstats_data (ucstats_data),
      .gnt          (gnt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // --------------------------------------------------
   // failure reporting and compares
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input ucstats_pkg::stat_word_t exp,
                             input ucstats_pkg::stat_word_t got);
      if (got !== exp) begin
         abort_run($sformatf("mismatch in %s: expected %h, got %h", name, exp, got));
      end
   endtask

   task automatic check_byte(input string name, input ucstats_pkg::uc_byte_t exp,
                             input ucstats_pkg::uc_byte_t got);
      if (got !== exp) begin
         abort_run($sformatf("mismatch in %s: expected %h, got %h", name, exp, got));
      end
   endtask

   // --------------------------------------------------
   // microcontroller pin drivers, all changes on the falling edge
   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic pulse_valid;
      @(negedge clk);
      valid = 1'b1;
      wait_cycles(HOLD_CYCLES);
      valid = 1'b0;
      wait_cycles(HOLD_CYCLES);
   endtask

   // data settles one cycle ahead of the strobe
   task automatic send_byte(input ucstats_pkg::uc_byte_t b);
      @(negedge clk);
      data_in = b;
      pulse_valid();
   endtask

   // cs up, then address low byte and high byte
   task automatic uc_start(input logic [15:0] addr);
      @(negedge clk);
      cs = 1'b1;
      wait_cycles(4);
      send_byte(addr[7:0]);
      send_byte(addr[15:8]);
   endtask

   task automatic uc_end;
      @(negedge clk);
      cs     = 1'b0;
      master = 1'b1;
      wait_cycles(6);
   endtask

   task automatic wait_val(input logic level);
      int n;
      n = 0;
      while (data_out_val !== level) begin
         if (n == WAIT_LIMIT) begin
            abort_run("timed out waiting for data_out_val to change");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   task automatic uc_write_burst(input logic [15:0] addr,
                                 input ucstats_pkg::stat_word_t words [BURST_LEN],
                                 input int n);
      uc_start(addr);
      for (int w = 0; w < n; w++) begin
         for (int b = 0; b < 4; b++) begin
            send_byte(words[w][b*8 +: 8]);
         end
      end
      uc_end();
   endtask

   // nbytes below 4 drops cs in the middle of the data phase
   task automatic uc_read(input string name, input logic [15:0] addr,
                          input ucstats_pkg::stat_word_t exp, input int nbytes);
      uc_start(addr);
      // falling strobe of the last address byte is done, hand the bus over
      master = 1'b0;
      for (int b = 0; b < nbytes; b++) begin
         wait_val(1'b1);
         check_byte(name, exp[b*8 +: 8], data_out);
         pulse_valid();
      end
      if (nbytes == 4) begin
         wait_val(1'b0);
      end
      uc_end();
   endtask

   // --------------------------------------------------
   // link engine drivers
   task automatic le_read(input string name, input ucstats_pkg::stat_addr_t base,
                          input ucstats_pkg::stat_word_t exp [BURST_LEN], input int n);
      @(negedge clk);
      if (gnt !== 1'b0) begin
         abort_run("gnt was high before le_req");
      end
      le_req = 1'b1;
      @(negedge clk);
      if (gnt !== 1'b1) begin
         abort_run("gnt did not follow le_req after one cycle");
      end
      le_req = 1'b0;
      // one address per cycle, data checked two cycles behind
      for (int i = 0; i < n + 2; i++) begin
         if (i >= 2) begin
            check_word(name, exp[i-2], ucstats_data);
         end
         if (i == 1 && gnt !== 1'b0) begin
            abort_run("gnt stayed high after le_req dropped");
         end
         if (i < n) begin
            le_addr = base + ucstats_pkg::stat_addr_t'(i);
         end
         @(negedge clk);
      end
   endtask

   task automatic le_done_pulse;
      @(negedge clk);
      le_done = 1'b1;
      @(negedge clk);
      le_done = 1'b0;
   endtask

   // --------------------------------------------------
   // pad enable may only be up while master is released
   // plus a short tail for cs or master to pass the synchronizers
   always @(posedge clk) begin
      if (!master) begin
         release_grace <= 5;
      end else if (release_grace > 0) begin
         release_grace <= release_grace - 1;
      end
   end

   always @(negedge clk) begin
      if (uc_rst_n && data_out_val && release_grace == 0) begin
         abort_run("data_out_val was high outside a read data phase");
      end
   end

   initial begin
      #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
      abort_run("watchdog expired before the tests finished");
   end

   `include "ucstats_tests.svh"

   initial begin
      uc_rst_n = 1'b0;
      cs       = 1'b0;
      valid    = 1'b0;
      master   = 1'b1;
      data_in  = '0;
      le_req   = 1'b0;
      le_addr  = '0;
      le_done  = 1'b0;
      void'($urandom(32'h4fe19cb8));
      wait_cycles(8);
      uc_rst_n = 1'b1;
      wait_cycles(4);
      run_all_tests();
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire
